// ==== Bender.yml ====
package:
  name: exe_stage

export_include_dirs:
  - .

sources:
  - cpuTypesPkg.sv
  - pipeTypesPkg.sv
  - exeStageIf.sv
  - exeStageReg.sv
  - exeAlu.sv
  - multHiLo.sv
  - exeOutput.sv
  - exeStage.sv
  - target: test
    files:
      - tb_exeStage.sv

// ==== compile.f ====
+incdir+.
cpuTypesPkg.sv
pipeTypesPkg.sv
exeStageIf.sv
exeStageReg.sv
exeAlu.sv
multHiLo.sv
exeOutput.sv
exeStage.sv
tb_exeStage.sv

// ==== cpuTypesPkg.sv ====
`include "exe_params.svh"

package cpuTypesPkg;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } rFormat_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } iFormat_t;

    // same instruction word, viewed as R or I format
    typedef union packed {
        rFormat_t r;
        iFormat_t i;
    } instrWord_u;

    typedef enum logic [4:0] {
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
        ALU_MULT, ALU_MULTU,  // handled by multHiLo
        ALU_NOP
    } aluOp_e;

endpackage

// ==== exeAlu.sv ====
`include "exe_params.svh"

module exeAlu
    import cpuTypesPkg::*;
(
    exeStageIf.consumer        stage,
    output logic [`DATA_W-1:0] aluOut,
    output logic               overflow
);

    localparam int MSB = `DATA_W - 1;

    logic [`DATA_W-1:0] opA;
    logic [`DATA_W-1:0] opB;
    logic [`DATA_W-1:0] immExt;
    logic [`DATA_W-1:0] sum;
    logic [`DATA_W-1:0] diff;
    logic               isLogic;

    assign isLogic = stage.aluOp inside {ALU_AND, ALU_OR, ALU_XOR, ALU_NOR};
    assign immExt  = isLogic ? {{(`DATA_W-16){1'b0}}, stage.instr.i.imm}
                             : {{(`DATA_W-16){stage.instr.i.imm[15]}}, stage.instr.i.imm};

    assign opA  = stage.aluSrcA ? {{(`DATA_W-5){1'b0}}, stage.instr.r.shamt} : stage.busA;
    assign opB  = stage.aluSrcB ? immExt : stage.busB;
    assign sum  = opA + opB;
    assign diff = opA - opB;

    always_comb begin
        aluOut   = '0;
        overflow = 1'b0;
        case (stage.aluOp)
            ALU_ADD: begin
                aluOut   = sum;
                overflow = (opA[MSB] == opB[MSB]) && (sum[MSB] != opA[MSB]);
            end
            ALU_SUB: begin
                aluOut   = diff;
                overflow = (opA[MSB] != opB[MSB]) && (diff[MSB] != opA[MSB]);
            end
            ALU_ADDU: aluOut = sum;
            ALU_SUBU: aluOut = diff;
            ALU_AND:  aluOut = opA & opB;
            ALU_OR:   aluOut = opA | opB;
            ALU_XOR:  aluOut = opA ^ opB;
            ALU_NOR:  aluOut = ~(opA | opB);
            ALU_SLT:  aluOut[0] = $signed(opA) < $signed(opB);
            ALU_SLTU: aluOut[0] = opA < opB;
            ALU_SLL:  aluOut = opB << opA[4:0];  // shift amount in A
            ALU_SRL:  aluOut = opB >> opA[4:0];
            ALU_SRA:  aluOut = $signed(opB) >>> opA[4:0];
            ALU_LUI:  aluOut = {opB[15:0], 16'b0};
            default:  aluOut = '0;  // mult ops and nop
        endcase
    end

endmodule

// ==== exeOutput.sv ====
`include "exe_params.svh"

module exeOutput
    import pipeTypesPkg::*;
(
    exeStageIf.consumer            stage,
    input  logic [`DATA_W-1:0]     aluOut,
    input  logic                   overflow,
    input  logic [`DATA_W-1:0]     hi,
    input  logic [`DATA_W-1:0]     lo,
    output logic [`DATA_W-1:0]     exeResult,
    output logic [`REG_ADDR_W-1:0] exeDst,
    output logic                   exeRegWr,
    output logic                   exeOverflow,
    output logic                   exePredFailed,
    output logic [`DATA_W-1:0]     exeCorrection
);

    logic               taken;
    logic [`DATA_W-1:0] pcPlus4;
    logic [`DATA_W-1:0] pcPlus8;
    logic [`DATA_W-1:0] brOffset;
    logic [`DATA_W-1:0] target;

    assign pcPlus4  = stage.pc + `DATA_W'(4);
    assign pcPlus8  = stage.pc + `DATA_W'(8);
    assign brOffset = {{(`DATA_W-18){stage.instr.i.imm[15]}}, stage.instr.i.imm, 2'b00};
    assign target   = (stage.branch == BR_JR) ? stage.busA : pcPlus4 + brOffset;

    always_comb begin
        case (stage.wbSel)
            WB_HI:   exeResult = hi;
            WB_LO:   exeResult = lo;
            WB_PC8:  exeResult = pcPlus8;
            default: exeResult = aluOut;
        endcase
        case (stage.dstSel)
            DST_RT:   exeDst = stage.instr.r.rt;
            DST_LINK: exeDst = `REG_ADDR_W'(`LINK_REG);
            default:  exeDst = stage.instr.r.rd;
        endcase
    end

    always_comb begin
        case (stage.branch)
            BR_BEQ:  taken = stage.busA == stage.busB;
            BR_BNE:  taken = stage.busA != stage.busB;
            BR_BLEZ: taken = $signed(stage.busA) <= 0;
            BR_BGTZ: taken = $signed(stage.busA) > 0;
            BR_BLTZ: taken = stage.busA[`DATA_W-1];
            BR_BGEZ: taken = !stage.busA[`DATA_W-1];
            BR_JR:   taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign exeRegWr    = stage.regWr && !overflow;  // no write-back on overflow
    assign exeOverflow = overflow;

    // wrong direction, or right direction to the wrong place
    assign exePredFailed = (taken != stage.predTaken) ||
                           (taken && (target != stage.predTarget));
    assign exeCorrection = taken ? target : pcPlus8;

endmodule

// ==== exeStage.sv ====
`include "exe_params.svh"

module exeStage
    import cpuTypesPkg::*;
    import pipeTypesPkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   exeWr,
    input  logic                   exeFlush,
    input  logic [`DATA_W-1:0]     idPc,
    input  instrWord_u             idInstr,
    input  logic [`DATA_W-1:0]     idBusA,
    input  logic [`DATA_W-1:0]     idBusB,
    input  aluOp_e                 idAluOp,
    input  logic                   idAluSrcA,
    input  logic                   idAluSrcB,
    input  wbSel_e                 idWbSel,
    input  dstSel_e                idDstSel,
    input  logic                   idRegWr,
    input  hiLoWr_t                idHiLoWr,
    input  branch_e                idBranch,
    input  logic                   idPredTaken,
    input  logic [`DATA_W-1:0]     idPredTarget,
    output logic [`DATA_W-1:0]     exeResult,
    output logic [`REG_ADDR_W-1:0] exeDst,
    output logic                   exeRegWr,
    output logic                   exeOverflow,
    output logic                   exePredFailed,
    output logic [`DATA_W-1:0]     exeCorrection,
    output logic                   multStall
);

    logic [`DATA_W-1:0] aluOut;
    logic               overflow;
    logic [`DATA_W-1:0] hi;
    logic [`DATA_W-1:0] lo;

    exeStageIf stage ();  // registered stage contents

    exeStageReg uStageReg (
        .clk, .rst, .exeWr, .exeFlush,
        .idPc, .idInstr, .idBusA, .idBusB, .idAluOp, .idAluSrcA, .idAluSrcB,
        .idWbSel, .idDstSel, .idRegWr, .idHiLoWr, .idBranch, .idPredTaken, .idPredTarget,
        .stage (stage.producer)
    );

    exeAlu uAlu (.stage (stage.consumer), .aluOut, .overflow);

    multHiLo uMultHiLo (
        .clk, .rst, .exeWr, .exeFlush,
        .stage (stage.consumer), .hi, .lo, .multStall
    );

    exeOutput uOutput (
        .stage (stage.consumer), .aluOut, .overflow, .hi, .lo,
        .exeResult, .exeDst, .exeRegWr, .exeOverflow, .exePredFailed, .exeCorrection
    );

endmodule

// ==== exeStageIf.sv ====
`include "exe_params.svh"

interface exeStageIf import cpuTypesPkg::*, pipeTypesPkg::*; ();

    logic [`DATA_W-1:0] pc;
    instrWord_u         instr;
    logic [`DATA_W-1:0] busA;
    logic [`DATA_W-1:0] busB;
    aluOp_e             aluOp;
    logic               aluSrcA;  // shamt as operand A
    logic               aluSrcB;  // immediate as operand B
    wbSel_e             wbSel;
    dstSel_e            dstSel;
    logic               regWr;
    hiLoWr_t            hiLoWr;
    branch_e            branch;
    logic               predTaken;
    logic [`DATA_W-1:0] predTarget;

    modport producer (output pc, instr, busA, busB, aluOp, aluSrcA, aluSrcB, wbSel, dstSel,
                      regWr, hiLoWr, branch, predTaken, predTarget);

    modport consumer (input pc, instr, busA, busB, aluOp, aluSrcA, aluSrcB, wbSel, dstSel,
                      regWr, hiLoWr, branch, predTaken, predTarget);

endinterface

// ==== exeStageReg.sv ====
`include "exe_params.svh"

module exeStageReg
    import cpuTypesPkg::*;
    import pipeTypesPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               exeWr,
    input  logic               exeFlush,
    input  logic [`DATA_W-1:0] idPc,
    input  instrWord_u         idInstr,
    input  logic [`DATA_W-1:0] idBusA,
    input  logic [`DATA_W-1:0] idBusB,
    input  aluOp_e             idAluOp,
    input  logic               idAluSrcA,
    input  logic               idAluSrcB,
    input  wbSel_e             idWbSel,
    input  dstSel_e            idDstSel,
    input  logic               idRegWr,
    input  hiLoWr_t            idHiLoWr,
    input  branch_e            idBranch,
    input  logic               idPredTaken,
    input  logic [`DATA_W-1:0] idPredTarget,
    exeStageIf.producer        stage
);

    // control fields, a bubble after reset or flush
    always_ff @(posedge clk) begin
        if (rst || exeFlush) begin
            stage.aluOp     <= ALU_NOP;
            stage.regWr     <= 1'b0;
            stage.hiLoWr    <= '0;
            stage.branch    <= BR_NONE;
            stage.predTaken <= 1'b0;  // no mispredict from a bubble
        end else if (exeWr) begin
            stage.aluOp     <= idAluOp;
            stage.regWr     <= idRegWr;
            stage.hiLoWr    <= idHiLoWr;
            stage.branch    <= idBranch;
            stage.predTaken <= idPredTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (exeWr) begin
            stage.pc         <= idPc;
            stage.instr      <= idInstr;
            stage.busA       <= idBusA;
            stage.busB       <= idBusB;
            stage.aluSrcA    <= idAluSrcA;
            stage.aluSrcB    <= idAluSrcB;
            stage.wbSel      <= idWbSel;
            stage.dstSel     <= idDstSel;
            stage.predTarget <= idPredTarget;
        end
    end

endmodule

// ==== exe_params.svh ====
`ifndef EXE_PARAMS_SVH
`define EXE_PARAMS_SVH

`define DATA_W      32  // datapath word
`define REG_ADDR_W  5
`define MULT_CYCLES 32  // one iteration per multiplier bit
`define LINK_REG    31

`endif

// ==== multHiLo.sv ====
`include "exe_params.svh"

module multHiLo
    import cpuTypesPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               exeWr,
    input  logic               exeFlush,
    exeStageIf.consumer        stage,
    output logic [`DATA_W-1:0] hi,
    output logic [`DATA_W-1:0] lo,
    output logic               multStall
);

    localparam int MSB   = `DATA_W - 1;
    localparam int CNT_W = $clog2(`MULT_CYCLES);

    logic [CNT_W-1:0]     cnt;
    logic                 done;
    logic                 isMult;
    logic                 signedOp;
    logic                 leave;
    logic [`DATA_W-1:0]   absA;
    logic [`DATA_W-1:0]   absB;
    logic [2*`DATA_W-1:0] prod;
    logic [2*`DATA_W-1:0] work;
    logic [2*`DATA_W-1:0] product;
    logic [`DATA_W:0]     partial;

    assign isMult    = (stage.aluOp == ALU_MULT) || (stage.aluOp == ALU_MULTU);
    assign signedOp  = stage.aluOp == ALU_MULT;
    assign leave     = exeWr || exeFlush;  // instruction leaves the stage
    assign multStall = isMult && !done;

    assign absA = (signedOp && stage.busA[MSB]) ? -stage.busA : stage.busA;
    assign absB = (signedOp && stage.busB[MSB]) ? -stage.busB : stage.busB;

    // multiplier sits in the low half, shifted out as the product comes in
    assign work    = (cnt == '0) ? {{`DATA_W{1'b0}}, absB} : prod;
    assign partial = {1'b0, work[2*`DATA_W-1:`DATA_W]} + (work[0] ? {1'b0, absA} : '0);
    assign product = (signedOp && (stage.busA[MSB] ^ stage.busB[MSB])) ? -prod : prod;

    always_ff @(posedge clk) begin
        if (rst || leave) begin
            cnt  <= '0;
            done <= 1'b0;
        end else if (multStall) begin
            cnt <= cnt + 1'b1;
            if (cnt == CNT_W'(`MULT_CYCLES - 1))
                done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (multStall)
            prod <= {partial, work[`DATA_W-1:1]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (leave) begin
            if (isMult && done) begin
                {hi, lo} <= product;
            end else begin  // mthi / mtlo, aborted multiply writes nothing
                if (stage.hiLoWr.hiWr) hi <= stage.busA;
                if (stage.hiLoWr.loWr) lo <= stage.busA;
            end
        end
    end

endmodule

// ==== pipeTypesPkg.sv ====
package pipeTypesPkg;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_HI,
        WB_LO,
        WB_PC8  // link value
    } wbSel_e;

    typedef enum logic [1:0] {
        DST_RD,
        DST_RT,
        DST_LINK
    } dstSel_e;

    typedef struct packed {
        logic hiWr;
        logic loWr;
    } hiLoWr_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLEZ,
        BR_BGTZ, BR_BLTZ, BR_BGEZ, BR_JR
    } branch_e;

endpackage

// ==== tb_exeStage.sv ====
`include "exe_params.svh"

module tb_exeStage
    import cpuTypesPkg::*;
    import pipeTypesPkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 10;
    localparam int N_ALU      = 64;
    localparam int N_OVF      = 4;
    localparam int N_MUL      = 8;
    localparam int N_BR       = 48;
    localparam int NUM_TESTS  = N_ALU + 4 * N_OVF + 7 * N_MUL + N_BR + 8;

    typedef struct packed {
        logic [`DATA_W-1:0] pc;
        instrWord_u         instr;
        logic [`DATA_W-1:0] busA;
        logic [`DATA_W-1:0] busB;
        aluOp_e             aluOp;
        logic               aluSrcA;
        logic               aluSrcB;
        wbSel_e             wbSel;
        dstSel_e            dstSel;
        logic               regWr;
        hiLoWr_t            hiLoWr;
        branch_e            branch;
        logic               predTaken;
        logic [`DATA_W-1:0] predTarget;
    } idFields_t;

    logic                   clk;
    logic                   rst;
    logic                   exeWr;
    logic                   exeFlush;
    idFields_t              drv;
    idFields_t              held;     // model of the stage register
    logic                   bubble;
    int                     mulCycles;
    logic [`DATA_W-1:0]     modelHi;
    logic [`DATA_W-1:0]     modelLo;
    logic [31:0]            lfsrState = 32'h7bf2_ae7e;
    int                     checkCount = 0;
    int                     errorCount = 0;
    logic [`DATA_W-1:0]     exeResult;
    logic [`REG_ADDR_W-1:0] exeDst;
    logic                   exeRegWr;
    logic                   exeOverflow;
    logic                   exePredFailed;
    logic [`DATA_W-1:0]     exeCorrection;
    logic                   multStall;

    exeStage dut0 (
        .clk, .rst, .exeWr, .exeFlush,
        .idPc (drv.pc), .idInstr (drv.instr), .idBusA (drv.busA), .idBusB (drv.busB),
        .idAluOp (drv.aluOp), .idAluSrcA (drv.aluSrcA), .idAluSrcB (drv.aluSrcB),
        .idWbSel (drv.wbSel), .idDstSel (drv.dstSel), .idRegWr (drv.regWr),
        .idHiLoWr (drv.hiLoWr), .idBranch (drv.branch), .idPredTaken (drv.predTaken),
        .idPredTarget (drv.predTarget),
        .exeResult, .exeDst, .exeRegWr, .exeOverflow, .exePredFailed, .exeCorrection,
        .multStall
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abortRun(input string line);
        errorCount++;
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkWord(input string what, input logic [`DATA_W-1:0] got,
                             input logic [`DATA_W-1:0] expected);
        checkCount++;
        if (got !== expected)
            abortRun($sformatf("FAIL at %0d ns: %s is %h, expected %h",
                               $time, what, got, expected));
    endtask

    task automatic checkDst(input string what, input logic [`REG_ADDR_W-1:0] got,
                            input logic [`REG_ADDR_W-1:0] expected);
        checkCount++;
        if (got !== expected)
            abortRun($sformatf("FAIL at %0d ns: %s is %0d, expected %0d",
                               $time, what, got, expected));
    endtask

    task automatic checkFlag(input string what, input logic got, input logic expected);
        checkCount++;
        if (got !== expected)
            abortRun($sformatf("FAIL at %0d ns: %s is %b, expected %b",
                               $time, what, got, expected));
    endtask

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsrBit();
        logic outBit;
        outBit    = lfsrState[0];
        lfsrState = (lfsrState >> 1) ^ (outBit ? 32'h8020_0003 : 32'h0);
        return outBit;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
            v = {v[30:0], lfsrBit()};
        return v;
    endfunction

    function automatic void refExe(input idFields_t f,
                                   input logic [`DATA_W-1:0] hiV,
                                   input logic [`DATA_W-1:0] loV,
                                   output logic [`DATA_W-1:0] res,
                                   output logic [`REG_ADDR_W-1:0] dst,
                                   output logic wr,
                                   output logic ovf);
        logic [`DATA_W-1:0]      a;
        logic [`DATA_W-1:0]      b;
        logic [`DATA_W-1:0]      alu;
        logic signed [`DATA_W:0] wide;  // one guard bit
        a = f.aluSrcA ? `DATA_W'(f.instr.r.shamt) : f.busA;
        if (!f.aluSrcB)
            b = f.busB;
        else if (f.aluOp inside {ALU_AND, ALU_OR, ALU_XOR, ALU_NOR})
            b = `DATA_W'(f.instr.i.imm);
        else
            b = `DATA_W'($signed(f.instr.i.imm));
        wide = '0;
        case (f.aluOp)
            ALU_ADD, ALU_ADDU: begin
                wide = $signed(a) + $signed(b);
                alu  = wide[`DATA_W-1:0];
            end
            ALU_SUB, ALU_SUBU: begin
                wide = $signed(a) - $signed(b);
                alu  = wide[`DATA_W-1:0];
            end
            ALU_AND:  alu = a & b;
            ALU_OR:   alu = a | b;
            ALU_XOR:  alu = a ^ b;
            ALU_NOR:  alu = ~(a | b);
            ALU_SLT:  alu = ($signed(a) < $signed(b)) ? 1 : 0;
            ALU_SLTU: alu = (a < b) ? 1 : 0;
            ALU_SLL:  alu = b << a[4:0];
            ALU_SRL:  alu = b >> a[4:0];
            ALU_SRA:  alu = $signed(b) >>> a[4:0];
            ALU_LUI:  alu = b << 16;
            default:  alu = '0;
        endcase
        ovf = (f.aluOp inside {ALU_ADD, ALU_SUB}) && (wide[`DATA_W] != wide[`DATA_W-1]);
        case (f.wbSel)
            WB_HI:   res = hiV;
            WB_LO:   res = loV;
            WB_PC8:  res = f.pc + 8;
            default: res = alu;
        endcase
        case (f.dstSel)
            DST_RT:   dst = f.instr.i.rt;
            DST_LINK: dst = `REG_ADDR_W'(`LINK_REG);
            default:  dst = f.instr.r.rd;
        endcase
        wr = f.regWr && !ovf;
    endfunction

    function automatic void refBranch(input idFields_t f, output logic miss,
                                      output logic [`DATA_W-1:0] corr);
        logic               taken;
        logic [`DATA_W-1:0] target;
        case (f.branch)
            BR_BEQ:  taken = f.busA == f.busB;
            BR_BNE:  taken = f.busA != f.busB;
            BR_BLEZ: taken = $signed(f.busA) <= 0;
            BR_BGTZ: taken = $signed(f.busA) > 0;
            BR_BLTZ: taken = $signed(f.busA) < 0;
            BR_BGEZ: taken = $signed(f.busA) >= 0;
            BR_JR:   taken = 1'b1;
            default: taken = 1'b0;
        endcase
        if (f.branch == BR_JR)
            target = f.busA;
        else
            target = f.pc + 4 + (`DATA_W'($signed(f.instr.i.imm)) << 2);
        miss = (taken != f.predTaken) || (taken && target != f.predTarget);
        corr = taken ? target : f.pc + 8;
    endfunction

    function automatic logic [2*`DATA_W-1:0] refProduct(input idFields_t f);
        logic signed [2*`DATA_W-1:0] sa;
        logic signed [2*`DATA_W-1:0] sb;
        if (f.aluOp == ALU_MULT) begin
            sa = $signed(f.busA);
            sb = $signed(f.busB);
        end else begin
            sa = {{`DATA_W{1'b0}}, f.busA};
            sb = {{`DATA_W{1'b0}}, f.busB};
        end
        return sa * sb;
    endfunction

    // reference model of the stage register and HI/LO
    always @(posedge clk) begin
        if (!rst && (exeWr || exeFlush)) begin
            if (held.aluOp inside {ALU_MULT, ALU_MULTU} && mulCycles >= `MULT_CYCLES) begin
                {modelHi, modelLo} <= refProduct(held);
            end else begin
                if (held.hiLoWr.hiWr)
                    modelHi <= held.busA;
                if (held.hiLoWr.loWr)
                    modelLo <= held.busA;
            end
        end
        if (rst) begin
            modelHi <= '0;
            modelLo <= '0;
        end
        if (rst || exeFlush) begin
            held.aluOp     <= ALU_NOP;
            held.regWr     <= 1'b0;
            held.hiLoWr    <= '0;
            held.branch    <= BR_NONE;
            held.predTaken <= 1'b0;
            bubble         <= 1'b1;
        end else if (exeWr) begin
            held   <= drv;
            bubble <= 1'b0;
        end
        if (rst || exeWr || exeFlush)
            mulCycles <= 0;
        else if (held.aluOp inside {ALU_MULT, ALU_MULTU} && mulCycles < `MULT_CYCLES)
            mulCycles <= mulCycles + 1;
    end

    always @(negedge clk) begin
        logic [`DATA_W-1:0]     expRes;
        logic [`REG_ADDR_W-1:0] expDst;
        logic                   expWr;
        logic                   expOvf;
        logic                   expMiss;
        logic [`DATA_W-1:0]     expCorr;
        if (!rst) begin
            refExe(held, modelHi, modelLo, expRes, expDst, expWr, expOvf);
            refBranch(held, expMiss, expCorr);
            checkFlag("exeRegWr", exeRegWr, expWr);
            checkFlag("exeOverflow", exeOverflow, expOvf);
            checkFlag("exePredFailed", exePredFailed, expMiss);
            checkFlag("multStall", multStall,
                      held.aluOp inside {ALU_MULT, ALU_MULTU} && mulCycles < `MULT_CYCLES);
            if (!bubble) begin
                checkWord("exeCorrection", exeCorrection, expCorr);
                if (held.regWr) begin  // result only matters when written
                    checkWord("exeResult", exeResult, expRes);
                    checkDst("exeDst", exeDst, expDst);
                end
            end
        end
    end

    function automatic idFields_t nopFields();
        idFields_t f;
        f            = '0;
        f.pc         = randBits(32) & ~32'h3;
        f.instr      = randBits(32);
        f.busA       = randBits(32);
        f.busB       = randBits(32);
        f.aluOp      = ALU_NOP;
        f.predTarget = randBits(32);
        return f;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic issue(input idFields_t f, input bit waitDone);
        int guard;
        @(posedge clk);
        drv   <= f;
        exeWr <= 1'b1;
        @(posedge clk);  // stage loads here
        exeWr <= 1'b0;
        drv   <= nopFields();  // fresh inputs that a stalled stage must not take
        @(negedge clk);
        guard = 0;
        while (waitDone && multStall) begin
            guard++;
            if (guard > `MULT_CYCLES + 2)
                abortRun("multiply stall did not end in time");
            @(negedge clk);
        end
    endtask

    task automatic flushStage();
        @(posedge clk);
        exeFlush <= 1'b1;
        @(posedge clk);
        exeFlush <= 1'b0;
        @(negedge clk);
    endtask

    task automatic moveFromHiLo();
        idFields_t f;
        f       = nopFields();
        f.wbSel = WB_HI;
        f.regWr = 1'b1;
        issue(f, 1'b1);
        f.wbSel = WB_LO;
        issue(f, 1'b1);
    endtask

    task automatic moveToHiLo();
        idFields_t f;
        f             = nopFields();
        f.hiLoWr.hiWr = 1'b1;
        issue(f, 1'b1);
        f             = nopFields();
        f.hiLoWr.loWr = 1'b1;
        issue(f, 1'b1);
    endtask

    task automatic aluTests();
        idFields_t f;
        for (int k = 0; k < N_ALU; k++) begin
            f         = nopFields();
            f.aluOp   = aluOp_e'(5'(k % 14));  // add through lui
            f.aluSrcA = lfsrBit();
            f.aluSrcB = lfsrBit();
            f.dstSel  = lfsrBit() ? DST_RT : DST_RD;
            f.regWr   = lfsrBit();
            issue(f, 1'b1);
            if (k % 16 == 0)
                idle(4);  // outputs must hold
        end
    endtask

    task automatic overflowTests();
        idFields_t   f;
        logic [31:0] big;
        logic [31:0] neg;
        for (int k = 0; k < N_OVF; k++) begin
            big = {2'b01, randBits(30)};
            neg = {2'b10, randBits(30)};
            for (int m = 0; m < 4; m++) begin
                f       = nopFields();
                f.aluOp = aluOp_e'(5'(m));  // add, addu, sub, subu
                f.busA  = big;
                f.busB  = (m < 2) ? big : neg;
                f.regWr = 1'b1;
                issue(f, 1'b1);
            end
        end
    endtask

    task automatic multTests();
        idFields_t f;
        moveFromHiLo();  // zero after reset
        for (int k = 0; k < N_MUL; k++) begin
            f       = nopFields();
            f.aluOp = (k % 2 == 0) ? ALU_MULT : ALU_MULTU;
            if (k >= 2) begin
                f.busA[31] = k[1];
                f.busB[31] = k[2];
            end
            issue(f, 1'b1);
            moveFromHiLo();
            moveToHiLo();
            moveFromHiLo();
        end
    endtask

    task automatic branchTests();
        idFields_t          f;
        logic               miss;
        logic [`DATA_W-1:0] target;
        for (int k = 0; k < N_BR; k++) begin
            f        = nopFields();
            f.branch = branch_e'(3'(1 + k % 7));
            if (randBits(2) == 0)
                f.busA = '0;
            if (lfsrBit())
                f.busB = f.busA;
            f.predTaken = lfsrBit();
            refBranch(f, miss, target);
            if (lfsrBit())
                f.predTarget = target;
            if (k % 4 == 0) begin  // link form
                f.wbSel  = WB_PC8;
                f.dstSel = DST_LINK;
                f.regWr  = 1'b1;
            end
            issue(f, 1'b1);
        end
    endtask

    task automatic flushTests();
        idFields_t f;
        f       = nopFields();
        f.aluOp = ALU_ADDU;
        f.regWr = 1'b1;
        issue(f, 1'b1);
        flushStage();
        f           = nopFields();
        f.branch    = BR_JR;
        f.predTaken = 1'b0;  // mispredicts until flushed
        issue(f, 1'b1);
        flushStage();
        f       = nopFields();
        f.aluOp = ALU_MULT;
        issue(f, 1'b0);
        idle(5);
        flushStage();  // abort mid multiply
        moveFromHiLo();
    endtask

    initial begin
        #(NUM_TESTS * (`MULT_CYCLES + 4) * CLK_PERIOD);
        abortRun("watchdog expired because the test run did not finish");
    end

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        exeWr    = 1'b0;
        exeFlush = 1'b0;
        drv      = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        aluTests();
        overflowTests();
        multTests();
        branchTests();
        flushTests();
        idle(2);
        if (errorCount == 0 && checkCount > 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            abortRun("run ended with failed checks or without any checks");
        end
    end

endmodule
